// File: verilog/mem_pkg.sv
package mem_pkg;

	localparam int ADDR_WIDTH = 12; // 4 KiB of L2
	localparam int DATA_WIDTH = 32;

	typedef enum logic [1:0] {
		BYTE = 2'd0,
		HALF = 2'd1,
		WORD = 2'd2
	} datasize_e;

	// Address step of one beat
	function automatic logic [2:0] size_bytes(datasize_e size);
		case (size)
			BYTE: return 3'd1;
			HALF: return 3'd2;
			default: return 3'd4;
		endcase
	endfunction

endpackage

// File: verilog/filter_pkg.sv
package filter_pkg;

	localparam int LEN_WIDTH = 8;
	localparam int FIFO_DEPTH = 4;

	typedef enum logic [1:0] {
		MODE_LINEAR = 2'd0,
		MODE_SLIDE = 2'd1,
		MODE_CIRC = 2'd2,
		MODE_2D = 2'd3
	} mode_e;

	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_MAX = 2'd2,
		OP_PASS_A = 2'd3
	} opcode_e;

	typedef enum logic {
		FETCH_IDLE = 1'b0,
		FETCH_RUN = 1'b1
	} fetch_state_e;

endpackage

// File: verilog/l2_sram.sv
module l2_sram (
	input logic clk_i,
	input logic resetn_i,
	input logic req_i,
	input logic [mem_pkg::ADDR_WIDTH-1:0] addr_i,
	input mem_pkg::datasize_e size_i,
	input logic we_i,
	input logic [mem_pkg::ADDR_WIDTH-1:0] waddr_i,
	input logic [mem_pkg::DATA_WIDTH-1:0] wdata_i,
	output logic rvalid_o,
	output logic [mem_pkg::DATA_WIDTH-1:0] rdata_o
);
	logic [7:0] mem [2**mem_pkg::ADDR_WIDTH];
	logic [mem_pkg::DATA_WIDTH-1:0] rd_word;

	// Little-endian lanes, upper bytes zero
	always_comb begin
		rd_word = '0;
		for (int i = 0; i < mem_pkg::DATA_WIDTH / 8; i++) begin
			if (3'(i) < mem_pkg::size_bytes(size_i))
				rd_word[8*i +: 8] = mem[{addr_i[mem_pkg::ADDR_WIDTH-1:2], addr_i[1:0] + 2'(i)}];
		end
	end

	always_ff @(posedge clk_i) begin
		if (we_i) begin
			for (int i = 0; i < mem_pkg::DATA_WIDTH / 8; i++)
				mem[{waddr_i[mem_pkg::ADDR_WIDTH-1:2], 2'(i)}] <= wdata_i[8*i +: 8];
		end
		if (req_i)
			rdata_o <= rd_word;
	end

	always_ff @(posedge clk_i or negedge resetn_i) begin
		if (!resetn_i)
			rvalid_o <= 1'b0;
		else
			rvalid_o <= req_i; // never stalls
	end

endmodule

// File: verilog/l2_arbiter.sv
module l2_arbiter (
	input logic clk_i,
	input logic resetn_i,
	input logic a_req_i,
	input logic [mem_pkg::ADDR_WIDTH-1:0] a_addr_i,
	input mem_pkg::datasize_e a_size_i,
	input logic b_req_i,
	input logic [mem_pkg::ADDR_WIDTH-1:0] b_addr_i,
	input mem_pkg::datasize_e b_size_i,
	input logic mem_rvalid_i,
	input logic [mem_pkg::DATA_WIDTH-1:0] mem_rdata_i,
	output logic a_gnt_o,
	output logic a_rvalid_o,
	output logic [mem_pkg::DATA_WIDTH-1:0] a_rdata_o,
	output logic b_gnt_o,
	output logic b_rvalid_o,
	output logic [mem_pkg::DATA_WIDTH-1:0] b_rdata_o,
	output logic mem_req_o,
	output logic [mem_pkg::ADDR_WIDTH-1:0] mem_addr_o,
	output mem_pkg::datasize_e mem_size_o
);
	logic prio_b_q; // B wins the next tie
	logic last_b_q; // owner of the reply in flight

	assign a_gnt_o = a_req_i && (!b_req_i || !prio_b_q);
	assign b_gnt_o = b_req_i && (!a_req_i || prio_b_q);

	assign mem_req_o = a_req_i || b_req_i;
	assign mem_addr_o = b_gnt_o ? b_addr_i : a_addr_i;
	assign mem_size_o = b_gnt_o ? b_size_i : a_size_i;

	// Reply one cycle after its grant
	assign a_rvalid_o = mem_rvalid_i && !last_b_q;
	assign b_rvalid_o = mem_rvalid_i && last_b_q;
	assign a_rdata_o = mem_rdata_i;
	assign b_rdata_o = mem_rdata_i;

	always_ff @(posedge clk_i or negedge resetn_i) begin
		if (!resetn_i) begin
			prio_b_q <= 1'b0;
			last_b_q <= 1'b0;
		end else begin
			if (a_req_i && b_req_i)
				prio_b_q <= !prio_b_q;
			last_b_q <= b_gnt_o;
		end
	end

endmodule

// File: verilog/tx_fifo_mark.sv
module tx_fifo_mark (
	input logic clk_i,
	input logic resetn_i,
	input logic sof_i,
	input logic eof_i,
	input logic gnt_i,
	input logic valid_i,
	input logic [mem_pkg::DATA_WIDTH-1:0] data_i,
	input logic ready_i,
	output logic req_o,
	output logic [mem_pkg::DATA_WIDTH-1:0] data_o,
	output logic valid_o,
	output logic sof_o,
	output logic eof_o
);
	typedef logic [$clog2(filter_pkg::FIFO_DEPTH):0] cnt_t;
	typedef logic [$clog2(filter_pkg::FIFO_DEPTH)-1:0] ptr_t;

	logic [mem_pkg::DATA_WIDTH-1:0] data_q [filter_pkg::FIFO_DEPTH];
	logic sof_q [filter_pkg::FIFO_DEPTH];
	logic eof_q [filter_pkg::FIFO_DEPTH];
	ptr_t alloc_ptr_q; // marks written here at grant
	ptr_t fill_ptr_q;  // oldest slot still waiting for data
	ptr_t rd_ptr_q;
	cnt_t alloc_cnt_q; // filled plus in flight
	cnt_t fill_cnt_q;
	logic pop;

	assign req_o = alloc_cnt_q < cnt_t'(filter_pkg::FIFO_DEPTH);
	assign valid_o = fill_cnt_q != '0;
	assign pop = valid_o && ready_i;
	assign data_o = data_q[rd_ptr_q];
	assign sof_o = sof_q[rd_ptr_q];
	assign eof_o = eof_q[rd_ptr_q];

	always_ff @(posedge clk_i or negedge resetn_i) begin
		if (!resetn_i) begin
			alloc_ptr_q <= '0;
			fill_ptr_q <= '0;
			rd_ptr_q <= '0;
			alloc_cnt_q <= '0;
			fill_cnt_q <= '0;
		end else begin
			if (gnt_i)
				alloc_ptr_q <= alloc_ptr_q + 1;
			if (valid_i)
				fill_ptr_q <= fill_ptr_q + 1;
			if (pop)
				rd_ptr_q <= rd_ptr_q + 1;
			alloc_cnt_q <= alloc_cnt_q + cnt_t'(gnt_i) - cnt_t'(pop);
			fill_cnt_q <= fill_cnt_q + cnt_t'(valid_i) - cnt_t'(pop);
		end
	end

	// Replies return in order, so data lands beside its marks
	always_ff @(posedge clk_i) begin
		if (gnt_i) begin
			sof_q[alloc_ptr_q] <= sof_i;
			eof_q[alloc_ptr_q] <= eof_i;
		end
		if (valid_i)
			data_q[fill_ptr_q] <= data_i;
	end

endmodule

// File: verilog/filter_tx_datafetch.sv
module filter_tx_datafetch (
	input logic clk_i,
	input logic resetn_i,
	input logic cmd_start_i,
	input logic [mem_pkg::ADDR_WIDTH-1:0] cfg_addr_i,
	input mem_pkg::datasize_e cfg_size_i,
	input filter_pkg::mode_e cfg_mode_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] cfg_len0_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] cfg_len1_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] cfg_len2_i,
	input logic mem_gnt_i,
	input logic mem_rvalid_i,
	input logic [mem_pkg::DATA_WIDTH-1:0] mem_rdata_i,
	input logic stream_ready_i,
	output logic cmd_done_o,
	output logic mem_req_o,
	output logic [mem_pkg::ADDR_WIDTH-1:0] mem_addr_o,
	output mem_pkg::datasize_e mem_size_o,
	output logic stream_valid_o,
	output logic [mem_pkg::DATA_WIDTH-1:0] stream_data_o,
	output logic stream_sof_o,
	output logic stream_eof_o
);
	filter_pkg::fetch_state_e state_q;
	filter_pkg::mode_e mode_q;
	mem_pkg::datasize_e size_q;
	logic [filter_pkg::LEN_WIDTH-1:0] len0_q;
	logic [filter_pkg::LEN_WIDTH-1:0] len1_q;
	logic [filter_pkg::LEN_WIDTH-1:0] len2_q;
	logic [filter_pkg::LEN_WIDTH-1:0] word_cnt_q;
	logic [filter_pkg::LEN_WIDTH-1:0] row_cnt_q;
	logic [mem_pkg::ADDR_WIDTH-1:0] row_start_q;
	logic [mem_pkg::ADDR_WIDTH-1:0] ptr_q;
	logic [mem_pkg::ADDR_WIDTH-1:0] inc;
	logic [mem_pkg::ADDR_WIDTH-1:0] next_start;
	logic fifo_req;
	logic start;
	logic beat;
	logic last_word;
	logic last_row;
	logic row_frame;
	logic beat_sof;
	logic beat_eof;

	assign start = (state_q == filter_pkg::FETCH_IDLE) && cmd_start_i;
	assign mem_req_o = fifo_req && (state_q == filter_pkg::FETCH_RUN);
	assign mem_addr_o = ptr_q;
	assign mem_size_o = size_q;
	assign beat = mem_req_o && mem_gnt_i;

	assign inc = {{(mem_pkg::ADDR_WIDTH - 3){1'b0}}, mem_pkg::size_bytes(size_q)};
	assign row_frame = (mode_q == filter_pkg::MODE_SLIDE) || (mode_q == filter_pkg::MODE_CIRC);
	assign last_word = word_cnt_q == len0_q;
	assign last_row = (mode_q == filter_pkg::MODE_LINEAR) || (row_cnt_q == len1_q);

	// 2D keeps all rows in one frame
	assign beat_sof = (word_cnt_q == '0) && (row_frame || (row_cnt_q == '0));
	assign beat_eof = last_word && (row_frame || last_row);
	assign cmd_done_o = beat && last_word && last_row;

	always_comb begin
		case (mode_q)
			filter_pkg::MODE_SLIDE: next_start = row_start_q + inc; // one element on
			filter_pkg::MODE_2D:
				next_start = row_start_q +
					{{(mem_pkg::ADDR_WIDTH - filter_pkg::LEN_WIDTH){1'b0}}, len2_q};
			default: next_start = row_start_q;
		endcase
	end

	always_ff @(posedge clk_i or negedge resetn_i) begin
		if (!resetn_i) begin
			state_q <= filter_pkg::FETCH_IDLE;
			mode_q <= filter_pkg::MODE_LINEAR;
			size_q <= mem_pkg::WORD;
			len0_q <= '0;
			len1_q <= '0;
			len2_q <= '0;
			word_cnt_q <= '0;
			row_cnt_q <= '0;
			row_start_q <= '0;
			ptr_q <= '0;
		end else if (start) begin
			state_q <= filter_pkg::FETCH_RUN;
			mode_q <= cfg_mode_i;
			size_q <= cfg_size_i;
			len0_q <= cfg_len0_i;
			len1_q <= cfg_len1_i;
			len2_q <= cfg_len2_i;
			word_cnt_q <= '0;
			row_cnt_q <= '0;
			row_start_q <= cfg_addr_i;
			ptr_q <= cfg_addr_i;
		end else if (beat) begin
			if (!last_word) begin
				word_cnt_q <= word_cnt_q + 1;
				ptr_q <= ptr_q + inc;
			end else if (!last_row) begin
				word_cnt_q <= '0;
				row_cnt_q <= row_cnt_q + 1;
				row_start_q <= next_start;
				ptr_q <= next_start;
			end else begin
				state_q <= filter_pkg::FETCH_IDLE; // final beat granted
			end
		end
	end

	tx_fifo_mark u_fifo (
		.clk_i(clk_i),
		.resetn_i(resetn_i),
		.sof_i(beat_sof),
		.eof_i(beat_eof),
		.gnt_i(beat),
		.valid_i(mem_rvalid_i),
		.data_i(mem_rdata_i),
		.ready_i(stream_ready_i),
		.req_o(fifo_req),
		.data_o(stream_data_o),
		.valid_o(stream_valid_o),
		.sof_o(stream_sof_o),
		.eof_o(stream_eof_o)
	);

endmodule

// File: verilog/filter_au.sv
module filter_au (
	input logic clk_i,
	input logic resetn_i,
	input filter_pkg::opcode_e op_i,
	input logic a_valid_i,
	input logic [mem_pkg::DATA_WIDTH-1:0] a_data_i,
	input logic a_sof_i,
	input logic a_eof_i,
	input logic b_valid_i,
	input logic [mem_pkg::DATA_WIDTH-1:0] b_data_i,
	input logic out_ready_i,
	output logic a_ready_o,
	output logic b_ready_o,
	output logic out_valid_o,
	output logic [mem_pkg::DATA_WIDTH-1:0] out_data_o,
	output logic out_sof_o,
	output logic out_eof_o
);
	logic take;
	logic [mem_pkg::DATA_WIDTH-1:0] result;

	// Pair only when both sides present and the output slot frees
	assign take = a_valid_i && b_valid_i && (!out_valid_o || out_ready_i);
	assign a_ready_o = take;
	assign b_ready_o = take;

	always_comb begin
		case (op_i)
			filter_pkg::OP_ADD: result = a_data_i + b_data_i;
			filter_pkg::OP_SUB: result = a_data_i - b_data_i;
			filter_pkg::OP_MAX: result = (a_data_i > b_data_i) ? a_data_i : b_data_i; // unsigned
			default: result = a_data_i;
		endcase
	end

	always_ff @(posedge clk_i or negedge resetn_i) begin
		if (!resetn_i)
			out_valid_o <= 1'b0;
		else if (take)
			out_valid_o <= 1'b1;
		else if (out_ready_i)
			out_valid_o <= 1'b0;
	end

	always_ff @(posedge clk_i) begin
		if (take) begin
			out_data_o <= result;
			out_sof_o <= a_sof_i; // frame follows operand A
			out_eof_o <= a_eof_i;
		end
	end

endmodule

// File: verilog/filter_top.sv
module filter_top (
	input logic clk_i,
	input logic resetn_i,
	input logic a_start_i,
	input logic [mem_pkg::ADDR_WIDTH-1:0] a_addr_i,
	input mem_pkg::datasize_e a_size_i,
	input filter_pkg::mode_e a_mode_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] a_len0_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] a_len1_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] a_len2_i,
	input logic b_start_i,
	input logic [mem_pkg::ADDR_WIDTH-1:0] b_addr_i,
	input mem_pkg::datasize_e b_size_i,
	input filter_pkg::mode_e b_mode_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] b_len0_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] b_len1_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] b_len2_i,
	input filter_pkg::opcode_e op_i,
	input logic out_ready_i,
	input logic host_we_i,
	input logic [mem_pkg::ADDR_WIDTH-1:0] host_addr_i,
	input logic [mem_pkg::DATA_WIDTH-1:0] host_wdata_i,
	output logic a_done_o,
	output logic b_done_o,
	output logic out_valid_o,
	output logic [mem_pkg::DATA_WIDTH-1:0] out_data_o,
	output logic out_sof_o,
	output logic out_eof_o
);
	logic a_req;
	logic a_gnt;
	logic a_rvalid;
	logic [mem_pkg::ADDR_WIDTH-1:0] a_addr;
	mem_pkg::datasize_e a_size;
	logic [mem_pkg::DATA_WIDTH-1:0] a_rdata;
	logic b_req;
	logic b_gnt;
	logic b_rvalid;
	logic [mem_pkg::ADDR_WIDTH-1:0] b_addr;
	mem_pkg::datasize_e b_size;
	logic [mem_pkg::DATA_WIDTH-1:0] b_rdata;
	logic mem_req;
	logic mem_rvalid;
	logic [mem_pkg::ADDR_WIDTH-1:0] mem_addr;
	mem_pkg::datasize_e mem_size;
	logic [mem_pkg::DATA_WIDTH-1:0] mem_rdata;
	logic a_valid;
	logic a_ready;
	logic a_sof;
	logic a_eof;
	logic [mem_pkg::DATA_WIDTH-1:0] a_data;
	logic b_valid;
	logic b_ready;
	logic [mem_pkg::DATA_WIDTH-1:0] b_data;

	filter_tx_datafetch u_fetch_a (
		.clk_i(clk_i), .resetn_i(resetn_i),
		.cmd_start_i(a_start_i), .cfg_addr_i(a_addr_i), .cfg_size_i(a_size_i),
		.cfg_mode_i(a_mode_i), .cfg_len0_i(a_len0_i), .cfg_len1_i(a_len1_i),
		.cfg_len2_i(a_len2_i),
		.mem_gnt_i(a_gnt), .mem_rvalid_i(a_rvalid), .mem_rdata_i(a_rdata),
		.stream_ready_i(a_ready), .cmd_done_o(a_done_o),
		.mem_req_o(a_req), .mem_addr_o(a_addr), .mem_size_o(a_size),
		.stream_valid_o(a_valid), .stream_data_o(a_data),
		.stream_sof_o(a_sof), .stream_eof_o(a_eof)
	);

	// Frame marks of B are not used downstream
	filter_tx_datafetch u_fetch_b (
		.clk_i(clk_i), .resetn_i(resetn_i),
		.cmd_start_i(b_start_i), .cfg_addr_i(b_addr_i), .cfg_size_i(b_size_i),
		.cfg_mode_i(b_mode_i), .cfg_len0_i(b_len0_i), .cfg_len1_i(b_len1_i),
		.cfg_len2_i(b_len2_i),
		.mem_gnt_i(b_gnt), .mem_rvalid_i(b_rvalid), .mem_rdata_i(b_rdata),
		.stream_ready_i(b_ready), .cmd_done_o(b_done_o),
		.mem_req_o(b_req), .mem_addr_o(b_addr), .mem_size_o(b_size),
		.stream_valid_o(b_valid), .stream_data_o(b_data),
		.stream_sof_o(), .stream_eof_o()
	);

	l2_arbiter u_arbiter (
		.clk_i(clk_i), .resetn_i(resetn_i),
		.a_req_i(a_req), .a_addr_i(a_addr), .a_size_i(a_size),
		.b_req_i(b_req), .b_addr_i(b_addr), .b_size_i(b_size),
		.mem_rvalid_i(mem_rvalid), .mem_rdata_i(mem_rdata),
		.a_gnt_o(a_gnt), .a_rvalid_o(a_rvalid), .a_rdata_o(a_rdata),
		.b_gnt_o(b_gnt), .b_rvalid_o(b_rvalid), .b_rdata_o(b_rdata),
		.mem_req_o(mem_req), .mem_addr_o(mem_addr), .mem_size_o(mem_size)
	);

	l2_sram u_sram (
		.clk_i(clk_i), .resetn_i(resetn_i),
		.req_i(mem_req), .addr_i(mem_addr), .size_i(mem_size),
		.we_i(host_we_i), .waddr_i(host_addr_i), .wdata_i(host_wdata_i),
		.rvalid_o(mem_rvalid), .rdata_o(mem_rdata)
	);

	filter_au u_au (
		.clk_i(clk_i), .resetn_i(resetn_i), .op_i(op_i),
		.a_valid_i(a_valid), .a_data_i(a_data), .a_sof_i(a_sof), .a_eof_i(a_eof),
		.b_valid_i(b_valid), .b_data_i(b_data), .out_ready_i(out_ready_i),
		.a_ready_o(a_ready), .b_ready_o(b_ready),
		.out_valid_o(out_valid_o), .out_data_o(out_data_o),
		.out_sof_o(out_sof_o), .out_eof_o(out_eof_o)
	);

endmodule

// File: tests/filter_checker.sv
module filter_checker (
	input logic clk_i,
	input logic resetn_i,
	input logic a_gnt_i,
	input logic b_gnt_i,
	input logic a_rvalid_i,
	input logic b_rvalid_i,
	input logic a_valid_i,
	input logic a_ready_i,
	input logic b_valid_i,
	input logic b_ready_i,
	input logic a_done_i,
	input logic b_done_i
);
	int fail_cnt = 0;

	// Each grant owns the next reply alone
	assert property (@(posedge clk_i) disable iff (!resetn_i)
		a_gnt_i |=> a_rvalid_i && !b_rvalid_i)
	else begin
		$error("reply of a channel A grant not routed to A alone one cycle later");
		fail_cnt++;
	end

	assert property (@(posedge clk_i) disable iff (!resetn_i)
		b_gnt_i |=> b_rvalid_i && !a_rvalid_i)
	else begin
		$error("reply of a channel B grant not routed to B alone one cycle later");
		fail_cnt++;
	end

	// Stream words stay offered until taken
	assert property (@(posedge clk_i) disable iff (!resetn_i) a_valid_i && !a_ready_i |=> a_valid_i)
	else begin
		$error("operand A stream valid dropped before ready");
		fail_cnt++;
	end

	assert property (@(posedge clk_i) disable iff (!resetn_i) b_valid_i && !b_ready_i |=> b_valid_i)
	else begin
		$error("operand B stream valid dropped before ready");
		fail_cnt++;
	end

	assert property (@(posedge clk_i) disable iff (!resetn_i) a_done_i |=> !a_done_i)
	else begin
		$error("done of channel A longer than one cycle");
		fail_cnt++;
	end

	assert property (@(posedge clk_i) disable iff (!resetn_i) b_done_i |=> !b_done_i)
	else begin
		$error("done of channel B longer than one cycle");
		fail_cnt++;
	end

endmodule

bind filter_top filter_checker u_check (
	.clk_i(clk_i),
	.resetn_i(resetn_i),
	.a_gnt_i(a_gnt),
	.b_gnt_i(b_gnt),
	.a_rvalid_i(a_rvalid),
	.b_rvalid_i(b_rvalid),
	.a_valid_i(a_valid),
	.a_ready_i(a_ready),
	.b_valid_i(b_valid),
	.b_ready_i(b_ready),
	.a_done_i(a_done_o),
	.b_done_i(b_done_o)
);

// File: tests/filter_monitor.sv
module filter_monitor (
	input logic clk_i,
	input logic host_we_i,
	input logic [mem_pkg::ADDR_WIDTH-1:0] host_addr_i,
	input logic [mem_pkg::DATA_WIDTH-1:0] host_wdata_i,
	input logic a_start_i,
	input logic [mem_pkg::ADDR_WIDTH-1:0] a_addr_i,
	input mem_pkg::datasize_e a_size_i,
	input filter_pkg::mode_e a_mode_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] a_len0_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] a_len1_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] a_len2_i,
	input logic b_start_i,
	input logic [mem_pkg::ADDR_WIDTH-1:0] b_addr_i,
	input mem_pkg::datasize_e b_size_i,
	input filter_pkg::mode_e b_mode_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] b_len0_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] b_len1_i,
	input logic [filter_pkg::LEN_WIDTH-1:0] b_len2_i,
	input filter_pkg::opcode_e op_i,
	input logic out_valid_i,
	input logic out_ready_i,
	input logic [mem_pkg::DATA_WIDTH-1:0] out_data_i,
	input logic out_sof_i,
	input logic out_eof_i,
	output int seen_o,
	output int errors_o
);
	logic [7:0] image [2**mem_pkg::ADDR_WIDTH]; // copy of the L2 contents
	logic [mem_pkg::DATA_WIDTH-1:0] exp_a [$];
	logic [1:0] exp_mark [$]; // sof and eof of operand A
	logic [mem_pkg::DATA_WIDTH-1:0] exp_b [$];
	string test_name = "none";
	int test_errs = 0;
	int seen_cnt = 0;
	int err_total = 0;
	int tests_run = 0;
	int tests_failed = 0;

	assign seen_o = seen_cnt;
	assign errors_o = err_total;

	function automatic int nbytes(mem_pkg::datasize_e size);
		case (size)
			mem_pkg::BYTE: return 1;
			mem_pkg::HALF: return 2;
			default: return 4;
		endcase
	endfunction

	function automatic logic [31:0] read_image(logic [mem_pkg::ADDR_WIDTH-1:0] addr, int n);
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < n; i++)
			w[8*i +: 8] = image[addr + 12'(i)];
		return w;
	endfunction

	// Expected words of one channel, row by row
	task automatic expand(input logic [mem_pkg::ADDR_WIDTH-1:0] base,
			input mem_pkg::datasize_e size, input filter_pkg::mode_e mode,
			input logic [7:0] len0, input logic [7:0] len1, input logic [7:0] len2,
			input bit is_a);
		int rows;
		int n;
		bit per_row;
		logic [mem_pkg::ADDR_WIDTH-1:0] row_addr;
		logic [mem_pkg::ADDR_WIDTH-1:0] addr;
		n = nbytes(size);
		rows = (mode == filter_pkg::MODE_LINEAR) ? 1 : int'(len1) + 1;
		per_row = (mode == filter_pkg::MODE_SLIDE) || (mode == filter_pkg::MODE_CIRC);
		for (int r = 0; r < rows; r++) begin
			case (mode)
				filter_pkg::MODE_SLIDE: row_addr = base + 12'(r * n);
				filter_pkg::MODE_2D: row_addr = base + 12'(r * int'(len2));
				default: row_addr = base;
			endcase
			for (int w = 0; w <= int'(len0); w++) begin
				addr = row_addr + 12'(w * n);
				if (is_a) begin
					exp_a.push_back(read_image(addr, n));
					exp_mark.push_back({w == 0 && (per_row || r == 0),
						w == int'(len0) && (per_row || r == rows - 1)});
				end else begin
					exp_b.push_back(read_image(addr, n));
				end
			end
		end
	endtask

	task automatic note_error();
		test_errs++;
		err_total++;
	endtask

	task automatic check_output();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] expect_word;
		logic [1:0] mark;
		seen_cnt++;
		if (exp_a.size() == 0 || exp_b.size() == 0) begin
			$display("%s: output %0d arrived with no expected word left", test_name, seen_cnt);
			note_error();
		end else begin
			a = exp_a.pop_front();
			b = exp_b.pop_front();
			mark = exp_mark.pop_front();
			case (op_i)
				filter_pkg::OP_ADD: expect_word = a + b;
				filter_pkg::OP_SUB: expect_word = a - b;
				filter_pkg::OP_MAX: expect_word = (a > b) ? a : b;
				default: expect_word = a;
			endcase
			if (out_data_i !== expect_word) begin
				$display("ERROR %s: data of output %0d expected %h actual %h",
					test_name, seen_cnt, expect_word, out_data_i);
				note_error();
			end
			if ({out_sof_i, out_eof_i} !== mark) begin
				$display("ERROR %s: sof/eof of output %0d expected %b actual %b",
					test_name, seen_cnt, mark, {out_sof_i, out_eof_i});
				note_error();
			end
		end
	endtask

	always @(posedge clk_i) begin
		if (host_we_i) begin
			for (int i = 0; i < 4; i++)
				image[{host_addr_i[mem_pkg::ADDR_WIDTH-1:2], 2'(i)}] = host_wdata_i[8*i +: 8];
		end
		if (a_start_i)
			expand(a_addr_i, a_size_i, a_mode_i, a_len0_i, a_len1_i, a_len2_i, 1'b1);
		if (b_start_i)
			expand(b_addr_i, b_size_i, b_mode_i, b_len0_i, b_len1_i, b_len2_i, 1'b0);
		if (out_valid_i && out_ready_i)
			check_output();
	end

	task automatic begin_test(input string name);
		test_name = name;
		test_errs = 0;
		seen_cnt = 0;
		exp_a.delete();
		exp_b.delete();
		exp_mark.delete();
	endtask

	task automatic end_test();
		if (exp_a.size() != 0 || exp_b.size() != 0) begin
			$display("%s: %0d expected outputs never arrived", test_name, exp_a.size());
			note_error();
		end
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("%s: %s, %0d outputs", test_name, (test_errs == 0) ? "ok" : "failed", seen_cnt);
	endtask

	task automatic report();
		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, err_total);
	endtask

endmodule

// File: tests/filter_tb.sv
module filter_tb;

	localparam int TIMEOUT = 2000; // cycles per wait

	logic clk;
	logic resetn;
	logic a_start;
	logic [mem_pkg::ADDR_WIDTH-1:0] a_addr;
	mem_pkg::datasize_e a_size;
	filter_pkg::mode_e a_mode;
	logic [filter_pkg::LEN_WIDTH-1:0] a_len0;
	logic [filter_pkg::LEN_WIDTH-1:0] a_len1;
	logic [filter_pkg::LEN_WIDTH-1:0] a_len2;
	logic b_start;
	logic [mem_pkg::ADDR_WIDTH-1:0] b_addr;
	mem_pkg::datasize_e b_size;
	filter_pkg::mode_e b_mode;
	logic [filter_pkg::LEN_WIDTH-1:0] b_len0;
	logic [filter_pkg::LEN_WIDTH-1:0] b_len1;
	logic [filter_pkg::LEN_WIDTH-1:0] b_len2;
	filter_pkg::opcode_e op;
	logic out_ready = 1'b1;
	logic host_we;
	logic [mem_pkg::ADDR_WIDTH-1:0] host_addr;
	logic [mem_pkg::DATA_WIDTH-1:0] host_wdata;
	logic a_done;
	logic b_done;
	logic out_valid;
	logic [mem_pkg::DATA_WIDTH-1:0] out_data;
	logic out_sof;
	logic out_eof;
	logic [31:0] lfsr = 32'hef5926ab;
	bit stall_en;
	bit run_failed;
	int seen;
	int errors;

	filter_top DUT (
		.clk_i(clk), .resetn_i(resetn),
		.a_start_i(a_start), .a_addr_i(a_addr), .a_size_i(a_size), .a_mode_i(a_mode),
		.a_len0_i(a_len0), .a_len1_i(a_len1), .a_len2_i(a_len2),
		.b_start_i(b_start), .b_addr_i(b_addr), .b_size_i(b_size), .b_mode_i(b_mode),
		.b_len0_i(b_len0), .b_len1_i(b_len1), .b_len2_i(b_len2),
		.op_i(op), .out_ready_i(out_ready),
		.host_we_i(host_we), .host_addr_i(host_addr), .host_wdata_i(host_wdata),
		.a_done_o(a_done), .b_done_o(b_done), .out_valid_o(out_valid),
		.out_data_o(out_data), .out_sof_o(out_sof), .out_eof_o(out_eof)
	);

	filter_monitor mon (
		.clk_i(clk), .host_we_i(host_we), .host_addr_i(host_addr), .host_wdata_i(host_wdata),
		.a_start_i(a_start), .a_addr_i(a_addr), .a_size_i(a_size), .a_mode_i(a_mode),
		.a_len0_i(a_len0), .a_len1_i(a_len1), .a_len2_i(a_len2),
		.b_start_i(b_start), .b_addr_i(b_addr), .b_size_i(b_size), .b_mode_i(b_mode),
		.b_len0_i(b_len0), .b_len1_i(b_len1), .b_len2_i(b_len2),
		.op_i(op), .out_valid_i(out_valid), .out_ready_i(out_ready),
		.out_data_i(out_data), .out_sof_i(out_sof), .out_eof_i(out_eof),
		.seen_o(seen), .errors_o(errors)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	// Random back-pressure, one LFSR step per cycle
	always @(negedge clk) begin
		if (stall_en) begin
			lfsr = lfsr_next(lfsr);
			out_ready = lfsr[0];
		end else begin
			out_ready = 1'b1;
		end
	end

	task automatic write_word(input logic [mem_pkg::ADDR_WIDTH-1:0] addr, input logic [31:0] data);
		@(negedge clk);
		host_we = 1'b1;
		host_addr = addr;
		host_wdata = data;
		@(negedge clk);
		host_we = 1'b0;
	endtask

	task automatic wait_done(input string name, output bit ok);
		bit a_seen;
		bit b_seen;
		int cycles;
		a_seen = 1'b0;
		b_seen = 1'b0;
		cycles = 0;
		while (cycles < TIMEOUT) begin
			a_seen |= a_done;
			b_seen |= b_done;
			if (a_seen && b_seen)
				break;
			@(negedge clk);
			cycles++;
		end
		ok = a_seen && b_seen;
		if (!ok)
			$display("%s: timed out waiting for the done pulses (A %0d, B %0d)", name, a_seen, b_seen);
	endtask

	task automatic wait_outputs(input string name, input int n, output bit ok);
		int cycles;
		cycles = 0;
		while (seen < n && cycles < TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		ok = seen >= n;
		if (!ok)
			$display("%s: timed out with %0d of %0d outputs received", name, seen, n);
	endtask

	task automatic run_test(input string name, input logic [31:0] v [14]);
		int n;
		bit ok;
		n = int'(v[3][7:0]) + 1; // one output per A beat
		if (filter_pkg::mode_e'(v[2][1:0]) != filter_pkg::MODE_LINEAR)
			n = n * (int'(v[4][7:0]) + 1);
		mon.begin_test(name);
		@(posedge clk);
		stall_en = v[13][0];
		@(negedge clk);
		a_addr = v[0][11:0];
		a_size = mem_pkg::datasize_e'(v[1][1:0]);
		a_mode = filter_pkg::mode_e'(v[2][1:0]);
		a_len0 = v[3][7:0];
		a_len1 = v[4][7:0];
		a_len2 = v[5][7:0];
		b_addr = v[6][11:0];
		b_size = mem_pkg::datasize_e'(v[7][1:0]);
		b_mode = filter_pkg::mode_e'(v[8][1:0]);
		b_len0 = v[9][7:0];
		b_len1 = v[10][7:0];
		b_len2 = v[11][7:0];
		op = filter_pkg::opcode_e'(v[12][1:0]);
		a_start = 1'b1;
		b_start = 1'b1;
		@(negedge clk);
		a_start = 1'b0;
		b_start = 1'b0;
		wait_done(name, ok);
		if (ok)
			wait_outputs(name, n, ok);
		@(posedge clk);
		stall_en = 1'b0;
		if (ok)
			repeat (4) @(negedge clk); // a stray extra output shows up here
		else
			run_failed = 1'b1;
		mon.end_test();
	endtask

	initial begin
		int fd;
		int got;
		string line;
		string name;
		logic [31:0] v [14];
		logic [31:0] addr;
		logic [31:0] data;
		resetn = 1'b0;
		a_start = 1'b0;
		a_addr = '0;
		a_size = mem_pkg::WORD;
		a_mode = filter_pkg::MODE_LINEAR;
		a_len0 = '0;
		a_len1 = '0;
		a_len2 = '0;
		b_start = 1'b0;
		b_addr = '0;
		b_size = mem_pkg::WORD;
		b_mode = filter_pkg::MODE_LINEAR;
		b_len0 = '0;
		b_len1 = '0;
		b_len2 = '0;
		op = filter_pkg::OP_ADD;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		stall_en = 1'b0;
		run_failed = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		resetn = 1'b1;

		fd = $fopen("tests/filter_tests.txt", "r");
		if (fd == 0) begin
			$display("could not open tests/filter_tests.txt");
			run_failed = 1'b1;
		end
		while (fd != 0 && !run_failed && !$feof(fd)) begin
			got = $fgets(line, fd);
			if (got > 0 && line.len() > 1 && line[0] != "#") begin
				if (line[0] == "M") begin
					got = $sscanf(line, "M %h %h", addr, data);
					write_word(addr[mem_pkg::ADDR_WIDTH-1:0], data);
				end else if (line[0] == "T") begin
					got = $sscanf(line, "T %s %h %h %h %h %h %h %h %h %h %h %h %h %h %h", name,
						v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
						v[10], v[11], v[12], v[13]);
					if (got != 15) begin
						$display("malformed test line in the data file: %s", line);
						run_failed = 1'b1;
					end else begin
						run_test(name, v);
					end
				end
			end
		end
		if (fd != 0)
			$fclose(fd);

		mon.report();
		if (!run_failed && errors == 0 && DUT.u_check.fail_cnt == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: tests/filter_tests.txt
# M <byte address> <data word>, written through the host port
# T <name> <A: addr size mode len0 len1 len2> <B: addr size mode len0 len1 len2> <op> <stall>
M 000 04030201
M 004 08070605
M 008 0c0b0a09
M 00c 100f0e0d
M 010 14131211
M 014 18171615
M 018 1c1b1a19
M 01c 201f1e1d
M 100 a0000001
M 104 7fffffff
M 108 00000010
M 10c 80000000
M 110 0000ffff
M 114 12345678
M 118 fedcba98
M 11c 00000003
T lin_add 000 2 0 07 00 00 100 2 0 07 00 00 0 0
T slide_sub 000 0 1 03 03 00 100 0 0 0f 00 00 1 0
T circ_max 100 1 2 03 02 00 000 2 3 02 03 04 2 0
T td_pass 000 2 3 01 02 0c 100 2 0 05 00 00 3 0
T lin_add_stall 000 2 0 07 00 00 100 2 0 07 00 00 0 1
T slide_sub_stall 000 0 1 03 03 00 100 0 0 0f 00 00 1 1
T mixed_stall 110 1 1 01 02 00 000 2 2 02 01 00 0 1

// File: list.f
verilog/mem_pkg.sv
verilog/filter_pkg.sv
verilog/l2_sram.sv
verilog/l2_arbiter.sv
verilog/tx_fifo_mark.sv
verilog/filter_tx_datafetch.sv
verilog/filter_au.sv
verilog/filter_top.sv
tests/filter_checker.sv
tests/filter_monitor.sv
tests/filter_tb.sv

// File: Makefile
TOP = filter_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	cat sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
